//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int INSTR_W    = 16;
    localparam int REG_ADDR_W = 5;
    localparam int IMD_W      = 12;
    localparam int BIT_W      = 3;

    typedef logic [INSTR_W-1:0] instr_t;

    typedef enum logic [4:0] {
        op_add,
        op_adc,
        op_and,
        op_brbc,
        op_brbs,
        op_cbi,
        op_cp,
        op_dec,
        op_eor,
        op_in,
        op_inc,
        op_ld_y,
        op_ldi,
        op_lds,
        op_mov,
        op_neg,
        op_nop,
        op_or,
        op_out,
        op_pop,
        op_push,
        op_rcall,
        op_ret,
        op_rjmp,
        op_sbi,
        op_sub,
        op_subi,
        op_sts,
        op_unknown
    } op_type_e;

    // bit positions inside op_group_t
    localparam int grp_alu_aux       = 0;
    localparam int grp_alu_imd       = 1;
    localparam int grp_alu_one_op    = 2;
    localparam int grp_alu_two_op    = 3;
    localparam int grp_alu           = 4;
    localparam int grp_load          = 5;
    localparam int grp_store         = 6;
    localparam int grp_stack         = 7;
    localparam int grp_memory        = 8;
    localparam int grp_register      = 9;
    localparam int grp_control_flow  = 10;
    localparam int grp_io_read       = 11;
    localparam int grp_io_write      = 12;
    localparam int grp_two_cycle_mem = 13;

    localparam int GROUP_COUNT = 14;

    typedef logic [GROUP_COUNT-1:0] op_group_t;

endpackage

`default_nettype wire

//--- decode_unit.sv
`default_nettype none

module decode_unit (
    input  decode_pkg::instr_t                  instr,
    output decode_pkg::op_type_e                op_type,
    output decode_pkg::op_group_t               op_group,
    output logic [decode_pkg::REG_ADDR_W-1:0]   rd,
    output logic [decode_pkg::REG_ADDR_W-1:0]   rr,
    output logic [decode_pkg::IMD_W-1:0]        imd,
    output logic [decode_pkg::BIT_W-1:0]        bit_sel
);
    import decode_pkg::*;

    logic [IMD_W-1:0] io_addr;
    logic [IMD_W-1:0] data_addr;

    assign io_addr   = {6'd0, instr[10:9], instr[3:0]};
    // 7-bit form of the 16-bit lds/sts address
    assign data_addr = {4'd0, ~instr[8], instr[8], instr[10:9], instr[3:0]};

    always_comb begin
        casez (instr)
            16'b0000_11??_????_???? : op_type = op_add;
            16'b0001_11??_????_???? : op_type = op_adc;
            16'b0010_00??_????_???? : op_type = op_and;
            16'b1111_01??_????_???? : op_type = op_brbc;
            16'b1111_00??_????_???? : op_type = op_brbs;
            16'b1001_1000_????_???? : op_type = op_cbi;
            16'b0001_01??_????_???? : op_type = op_cp;
            16'b1001_010?_????_1010 : op_type = op_dec;
            16'b0010_01??_????_???? : op_type = op_eor;
            16'b1011_0???_????_???? : op_type = op_in;
            16'b1001_010?_????_0011 : op_type = op_inc;
            16'b1000_000?_????_1000 : op_type = op_ld_y;
            16'b1110_????_????_???? : op_type = op_ldi;
            16'b1010_0???_????_???? : op_type = op_lds;
            16'b0010_11??_????_???? : op_type = op_mov;
            16'b1001_010?_????_0001 : op_type = op_neg;
            16'b0000_0000_0000_0000 : op_type = op_nop;
            16'b0010_10??_????_???? : op_type = op_or;
            16'b1011_1???_????_???? : op_type = op_out;
            16'b1001_000?_????_1111 : op_type = op_pop;
            16'b1001_001?_????_1111 : op_type = op_push;
            16'b1101_????_????_???? : op_type = op_rcall;
            16'b1001_0101_0000_1000 : op_type = op_ret;
            16'b1100_????_????_???? : op_type = op_rjmp;
            16'b1001_1010_????_???? : op_type = op_sbi;
            16'b0001_10??_????_???? : op_type = op_sub;
            16'b0101_????_????_???? : op_type = op_subi;
            16'b1010_1???_????_???? : op_type = op_sts;
            default                 : op_type = op_unknown;
        endcase
    end

    // field extraction, unused fields stay zero
    always_comb begin
        rd      = '0;
        rr      = '0;
        imd     = '0;
        bit_sel = '0;
        case (op_type)
            op_add, op_adc, op_and, op_cp, op_eor, op_mov, op_or, op_sub: begin
                rd = instr[8:4];
                rr = {instr[9], instr[3:0]};
            end
            op_dec, op_inc, op_neg, op_pop, op_ld_y: begin
                rd = instr[8:4];
            end
            op_push: begin
                rr = instr[8:4];
            end
            op_in: begin
                rd  = instr[8:4];
                imd = io_addr;
            end
            op_out: begin
                rr  = instr[8:4];
                imd = io_addr;
            end
            op_brbc, op_brbs: begin
                bit_sel = instr[2:0];                       // sreg bit
                imd     = {{5{instr[9]}}, instr[9:3]};      // signed offset
            end
            op_cbi, op_sbi: begin
                bit_sel = instr[2:0];
                imd     = {7'd0, instr[7:3]};               // low io space only
            end
            op_ldi, op_subi: begin
                rd  = {1'b1, instr[7:4]};                   // r16..r31
                imd = {4'd0, instr[11:8], instr[3:0]};
            end
            op_lds: begin
                rd  = {1'b1, instr[7:4]};
                imd = data_addr;
            end
            op_sts: begin
                rr  = {1'b1, instr[7:4]};
                imd = data_addr;
            end
            op_rcall, op_rjmp: begin
                imd = instr[11:0];
            end
            default: ;
        endcase
    end

    always_comb begin
        op_group = '0;

        op_group[grp_alu_aux]    = op_type inside {op_sbi, op_cbi};
        op_group[grp_alu_imd]    = op_type inside {op_inc, op_dec, op_subi};
        op_group[grp_alu_one_op] = (op_type == op_neg);
        op_group[grp_alu_two_op] = op_type inside {op_add, op_adc, op_sub, op_and,
                                                   op_eor, op_or, op_cp};
        op_group[grp_alu]        = op_group[grp_alu_one_op] | op_group[grp_alu_two_op];

        op_group[grp_load]   = op_type inside {op_lds, op_ld_y, op_pop, op_ret};
        op_group[grp_store]  = op_type inside {op_sts, op_push, op_rcall};
        op_group[grp_stack]  = op_type inside {op_push, op_pop, op_rcall, op_ret};
        op_group[grp_memory] = op_group[grp_load] | op_group[grp_store];

        op_group[grp_register]     = op_type inside {op_ldi, op_mov};
        op_group[grp_control_flow] = op_type inside {op_brbs, op_brbc, op_rjmp,
                                                     op_rcall, op_ret};

        // sreg and sp live in io space
        op_group[grp_io_read]  = (op_type == op_in) || (op_type == op_adc) ||
                                 op_group[grp_stack] || op_group[grp_alu_aux];
        op_group[grp_io_write] = (op_type == op_out) || op_group[grp_alu] ||
                                 op_group[grp_stack] || op_group[grp_alu_aux];

        // return address needs two stack bytes
        op_group[grp_two_cycle_mem] = op_type inside {op_rcall, op_ret};
    end

endmodule

`default_nettype wire

//--- flow_predictor.sv
`default_nettype none

module flow_predictor #(
    parameter int PC_WIDTH  = 10,
    parameter int RAS_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  decode_pkg::instr_t  instr,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic                ras_push,
    input  logic                ras_pop,
    output logic [PC_WIDTH-1:0] seq_pc,
    output logic [PC_WIDTH-1:0] jump_target,
    output logic [PC_WIDTH-1:0] branch_target,
    output logic [PC_WIDTH-1:0] ras_top,
    output logic                ras_empty
);

    localparam int EXT_W = (PC_WIDTH > 12) ? PC_WIDTH : 12;
    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);

    logic [EXT_W-1:0]    jump_off;
    logic [EXT_W-1:0]    branch_off;
    logic [PC_WIDTH-1:0] ras_mem [RAS_DEPTH];
    logic [PTR_W-1:0]    top_ptr;   // newest entry
    logic [PTR_W-1:0]    next_ptr;
    logic [PTR_W-1:0]    prev_ptr;
    logic [CNT_W-1:0]    fill;

    assign jump_off   = EXT_W'($signed(instr[11:0]));
    assign branch_off = EXT_W'($signed(instr[9:3]));

    // all sums wrap at PC_WIDTH
    assign seq_pc        = pc + PC_WIDTH'(1);
    assign jump_target   = seq_pc + jump_off[PC_WIDTH-1:0];
    assign branch_target = seq_pc + branch_off[PC_WIDTH-1:0];

    assign next_ptr = (top_ptr == PTR_W'(RAS_DEPTH - 1)) ? '0 : top_ptr + PTR_W'(1);
    assign prev_ptr = (top_ptr == '0) ? PTR_W'(RAS_DEPTH - 1) : top_ptr - PTR_W'(1);

    assign ras_top   = ras_mem[top_ptr];
    assign ras_empty = (fill == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '0;
            fill    <= '0;
        end else if (ras_push) begin
            top_ptr <= next_ptr;    // full stack overwrites the oldest
            if (fill != CNT_W'(RAS_DEPTH))
                fill <= fill + CNT_W'(1);
        end else if (ras_pop && !ras_empty) begin
            top_ptr <= prev_ptr;
            fill    <= fill - CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ras_push)
            ras_mem[next_ptr] <= seq_pc;
    end

endmodule

`default_nettype wire

//--- issue_unit.sv
`default_nettype none

module issue_unit #(
    parameter int PC_WIDTH = 10
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_req,
    input  logic [PC_WIDTH-1:0]                 in_pc,
    input  decode_pkg::op_type_e                op_type,
    input  decode_pkg::op_group_t               op_group,
    input  logic [decode_pkg::REG_ADDR_W-1:0]   rd,
    input  logic [decode_pkg::REG_ADDR_W-1:0]   rr,
    input  logic [decode_pkg::IMD_W-1:0]        imd,
    input  logic [decode_pkg::BIT_W-1:0]        bit_sel,
    input  logic [PC_WIDTH-1:0]                 seq_pc,
    input  logic [PC_WIDTH-1:0]                 jump_target,
    input  logic [PC_WIDTH-1:0]                 branch_target,
    input  logic [PC_WIDTH-1:0]                 ras_top,
    input  logic                                ras_empty,
    input  logic                                out_ack,
    output logic                                in_ack,
    output logic                                ras_push,
    output logic                                ras_pop,
    output logic                                out_req,
    output decode_pkg::op_type_e                out_type,
    output decode_pkg::op_group_t               out_group,
    output logic [decode_pkg::REG_ADDR_W-1:0]   out_rd,
    output logic [decode_pkg::REG_ADDR_W-1:0]   out_rr,
    output logic [decode_pkg::IMD_W-1:0]        out_imd,
    output logic [decode_pkg::BIT_W-1:0]        out_bit,
    output logic [PC_WIDTH-1:0]                 out_pc,
    output logic [PC_WIDTH-1:0]                 out_branch_target,
    output logic [PC_WIDTH-1:0]                 out_next_pc
);
    import decode_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_ack_issue,       // in_ack and out_req both up
        st_wait_release,    // out side acked, fetch side may still hold req
        st_wait_ack_low
    } state_e;

    state_e              state;
    logic                accept;
    logic [PC_WIDTH-1:0] next_pc;

    assign accept   = (state == st_idle) && in_req;
    assign ras_push = accept && (op_type == op_rcall);
    assign ras_pop  = accept && (op_type == op_ret);

    // next fetch address, conditional branches predicted not taken
    always_comb begin
        case (op_type)
            op_rjmp, op_rcall: next_pc = jump_target;
            op_ret:            next_pc = ras_empty ? '0 : ras_top;
            default:           next_pc = seq_pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            if (in_ack && !in_req)
                in_ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (in_req) begin
                        in_ack  <= 1'b1;
                        out_req <= 1'b1;
                        state   <= st_ack_issue;
                    end
                end
                st_ack_issue: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= st_wait_release;
                    end
                end
                st_wait_release: begin
                    if (!in_ack)
                        state <= (!in_req && !out_ack) ? st_idle : st_wait_ack_low;
                end
                st_wait_ack_low: begin
                    if (!in_req && !out_ack)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // issued record, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            out_type          <= op_type;
            out_group         <= op_group;
            out_rd            <= rd;
            out_rr            <= rr;
            out_imd           <= imd;
            out_bit           <= bit_sel;
            out_pc            <= in_pc;
            out_branch_target <= branch_target;
            out_next_pc       <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage_top.sv
`default_nettype none

module decode_stage_top #(
    parameter int PC_WIDTH  = 10,
    parameter int RAS_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_req,
    input  decode_pkg::instr_t                  in_instr,
    input  logic [PC_WIDTH-1:0]                 in_pc,
    input  logic                                out_ack,
    output logic                                in_ack,
    output logic                                out_req,
    output decode_pkg::op_type_e                out_type,
    output decode_pkg::op_group_t               out_group,
    output logic [decode_pkg::REG_ADDR_W-1:0]   out_rd,
    output logic [decode_pkg::REG_ADDR_W-1:0]   out_rr,
    output logic [decode_pkg::IMD_W-1:0]        out_imd,
    output logic [decode_pkg::BIT_W-1:0]        out_bit,
    output logic [PC_WIDTH-1:0]                 out_pc,
    output logic [PC_WIDTH-1:0]                 out_branch_target,
    output logic [PC_WIDTH-1:0]                 out_next_pc
);
    import decode_pkg::*;

    op_type_e               op_type;
    op_group_t              op_group;
    logic [REG_ADDR_W-1:0]  rd;
    logic [REG_ADDR_W-1:0]  rr;
    logic [IMD_W-1:0]       imd;
    logic [BIT_W-1:0]       bit_sel;
    logic [PC_WIDTH-1:0]    seq_pc;
    logic [PC_WIDTH-1:0]    jump_target;
    logic [PC_WIDTH-1:0]    branch_target;
    logic [PC_WIDTH-1:0]    ras_top;
    logic                   ras_empty;
    logic                   ras_push;
    logic                   ras_pop;

    decode_unit decode_i (
        .instr    (in_instr),
        .op_type  (op_type),
        .op_group (op_group),
        .rd       (rd),
        .rr       (rr),
        .imd      (imd),
        .bit_sel  (bit_sel)
    );

    flow_predictor #(
        .PC_WIDTH  (PC_WIDTH),
        .RAS_DEPTH (RAS_DEPTH)
    ) flow_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (in_instr),
        .pc            (in_pc),
        .ras_push      (ras_push),
        .ras_pop       (ras_pop),
        .seq_pc        (seq_pc),
        .jump_target   (jump_target),
        .branch_target (branch_target),
        .ras_top       (ras_top),
        .ras_empty     (ras_empty)
    );

    issue_unit #(
        .PC_WIDTH (PC_WIDTH)
    ) issue_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_req            (in_req),
        .in_pc             (in_pc),
        .op_type           (op_type),
        .op_group          (op_group),
        .rd                (rd),
        .rr                (rr),
        .imd               (imd),
        .bit_sel           (bit_sel),
        .seq_pc            (seq_pc),
        .jump_target       (jump_target),
        .branch_target     (branch_target),
        .ras_top           (ras_top),
        .ras_empty         (ras_empty),
        .out_ack           (out_ack),
        .in_ack            (in_ack),
        .ras_push          (ras_push),
        .ras_pop           (ras_pop),
        .out_req           (out_req),
        .out_type          (out_type),
        .out_group         (out_group),
        .out_rd            (out_rd),
        .out_rr            (out_rr),
        .out_imd           (out_imd),
        .out_bit           (out_bit),
        .out_pc            (out_pc),
        .out_branch_target (out_branch_target),
        .out_next_pc       (out_next_pc)
    );

endmodule

`default_nettype wire

//--- decode_checker.sv
`default_nettype none

module decode_checker #(
    parameter int PC_WIDTH = 10
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              in_req,
    input logic                              in_ack,
    input logic                              out_req,
    input logic                              out_ack,
    input decode_pkg::op_type_e              out_type,
    input decode_pkg::op_group_t             out_group,
    input logic [decode_pkg::REG_ADDR_W-1:0] out_rd,
    input logic [decode_pkg::REG_ADDR_W-1:0] out_rr,
    input logic [decode_pkg::IMD_W-1:0]      out_imd,
    input logic [decode_pkg::BIT_W-1:0]      out_bit,
    input logic [PC_WIDTH-1:0]               out_pc,
    input logic [PC_WIDTH-1:0]               out_branch_target,
    input logic [PC_WIDTH-1:0]               out_next_pc
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack");

    // record frozen while offered
    fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable({out_type, out_group, out_rd, out_rr,
            out_imd, out_bit, out_pc, out_branch_target, out_next_pc}))
        else $error("out_ fields changed while out_req high");

    ack_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> !in_ack)
        else $error("in_ack high after reset");

endmodule

bind decode_stage_top decode_checker #(.PC_WIDTH(PC_WIDTH)) checker_i (.*);

`default_nettype wire

//--- tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;
    import decode_pkg::*;

    localparam int PCW   = 10;
    localparam int DEPTH = 4;
    localparam int TMO   = 50;

    logic clk, rst_n, in_req, out_ack, in_ack, out_req;
    instr_t in_instr;
    logic [PCW-1:0] in_pc, out_pc, out_branch_target, out_next_pc;
    op_type_e out_type;
    op_group_t out_group;
    logic [REG_ADDR_W-1:0] out_rd, out_rr;
    logic [IMD_W-1:0] out_imd;
    logic [BIT_W-1:0] out_bit;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err0 = 0;
    integer seed = 46;
    logic [PCW-1:0] ras_model [$];   // newest at the back

    decode_stage_top #(.PC_WIDTH(PCW), .RAS_DEPTH(DEPTH)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int sext(input int v, input int w);
        return v[w-1] ? v - (1 << w) : v;
    endfunction

    function automatic op_group_t flag(input int i);
        return op_group_t'(1) << i;
    endfunction

    // expected group flags per opcode
    function automatic op_group_t exp_group(input op_type_e t);
        op_group_t alu2;
        op_group_t stk;
        alu2 = flag(grp_alu_two_op) | flag(grp_alu) | flag(grp_io_write);
        stk  = flag(grp_stack) | flag(grp_memory) | flag(grp_io_read) | flag(grp_io_write);
        case (t)
            op_add, op_and, op_eor, op_or, op_cp, op_sub: return alu2;
            op_adc:  return alu2 | flag(grp_io_read);   // carry in from sreg
            op_neg:  return flag(grp_alu_one_op) | flag(grp_alu) | flag(grp_io_write);
            op_inc, op_dec, op_subi: return flag(grp_alu_imd);
            op_sbi, op_cbi: return flag(grp_alu_aux) | flag(grp_io_read) | flag(grp_io_write);
            op_lds, op_ld_y: return flag(grp_load) | flag(grp_memory);
            op_sts:  return flag(grp_store) | flag(grp_memory);
            op_pop:  return stk | flag(grp_load);
            op_push: return stk | flag(grp_store);
            op_ret:  return stk | flag(grp_load) | flag(grp_control_flow) |
                            flag(grp_two_cycle_mem);
            op_rcall: return stk | flag(grp_store) | flag(grp_control_flow) |
                             flag(grp_two_cycle_mem);
            op_ldi, op_mov: return flag(grp_register);
            op_brbs, op_brbc, op_rjmp: return flag(grp_control_flow);
            op_in:   return flag(grp_io_read);
            op_out:  return flag(grp_io_write);
            default: return '0;
        endcase
    endfunction

    task automatic report(input string what, input instr_t w);
        $display("CHECK FAILED at %0t: %s wrong for word %h", $time, what, w);
        errors++;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // 0: in_ack high, 1: in_ack low, 2: out_req low
    task automatic wait_for(input int which);
        int n;
        logic ok;
        n = 0;
        ok = (which == 0) ? in_ack : (which == 1) ? !in_ack : !out_req;
        while (!ok && n < TMO) begin
            tick();
            n++;
            ok = (which == 0) ? in_ack : (which == 1) ? !in_ack : !out_req;
        end
        if (!ok) begin
            $display("timeout: handshake step %0d never completed at %0t", which, $time);
            errors++;
        end
    endtask

    task automatic send(input instr_t w, input logic [PCW-1:0] pc, input op_type_e t,
                        input int rd, input int rr, input int imd, input int b, input int delay);
        logic [PCW-1:0] seq, jmp, br, nxt;
        seq = PCW'(pc + 1);
        jmp = PCW'(int'(pc) + 1 + sext(int'(w[11:0]), 12));
        br  = PCW'(int'(pc) + 1 + sext(int'(w[9:3]), 7));
        nxt = seq;
        if (t == op_rjmp || t == op_rcall)
            nxt = jmp;
        if (t == op_rcall) begin
            if (ras_model.size() == DEPTH)
                void'(ras_model.pop_front());   // oldest dropped
            ras_model.push_back(seq);
        end
        if (t == op_ret)
            nxt = (ras_model.size() == 0) ? '0 : ras_model.pop_back();
        in_instr = w;
        in_pc    = pc;
        in_req   = 1'b1;
        wait_for(0);
        assert (out_req) else report("out_req", w);
        assert (out_type == t) else report("out_type", w);
        assert (out_group == exp_group(t)) else report("out_group", w);
        assert (out_rd == REG_ADDR_W'(rd) && out_rr == REG_ADDR_W'(rr)) else report("regs", w);
        assert (out_imd == IMD_W'(imd)) else report("out_imd", w);
        assert (out_bit == BIT_W'(b)) else report("out_bit", w);
        assert (out_pc == pc && out_branch_target == br) else report("pc/branch", w);
        assert (out_next_pc == nxt) else report("out_next_pc", w);
        in_req = 1'b0;
        wait_for(1);
        in_instr = 16'h9508;            // second offer while the record is held
        in_req   = (delay > 0);
        repeat (delay) begin
            tick();
            assert (out_req && !in_ack && out_type == t && out_pc == pc)
                else report("held handshake", w);
        end
        in_req  = 1'b0;
        out_ack = 1'b1;
        wait_for(2);
        out_ack = 1'b0;
        tick();
    endtask

    task automatic branch(input logic clr, input int k, input int s, input logic [PCW-1:0] pc);
        instr_t w;
        w = {5'b11110, clr, 7'(k), 3'(s)};
        send(w, pc, clr ? op_brbc : op_brbs, 0, 0, sext(k & 8'h7f, 7) & 12'hfff, s, 0);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_err0)
            tests_failed++;
        $display("test %s: %s", name, (errors != test_err0) ? "FAIL" : "ok");
        test_err0 = errors;
    endtask

    initial begin
        instr_t w;
        rst_n = 1'b0;
        in_req = 1'b0;
        out_ack = 1'b0;
        in_instr = '0;
        in_pc = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        assert (!in_ack && !out_req) else report("reset state", '0);
        finish_test("reset");

        send(16'h0C12, 10'h001, op_add, 1, 2, 0, 0, 0);
        send(16'h1E51, 10'h002, op_adc, 5, 17, 0, 0, 1);
        send(16'h2000, 10'h003, op_and, 0, 0, 0, 0, 0);
        send(16'h2400, 10'h004, op_eor, 0, 0, 0, 0, 0);
        send(16'h2800, 10'h005, op_or, 0, 0, 0, 0, 0);
        send(16'h1400, 10'h006, op_cp, 0, 0, 0, 0, 0);
        send(16'h1800, 10'h007, op_sub, 0, 0, 0, 0, 0);
        send(16'h2DF0, 10'h008, op_mov, 31, 0, 0, 0, 0);
        send(16'hEA4B, 10'h009, op_ldi, 20, 0, 12'h0AB, 0, 0);
        send(16'h5005, 10'h00A, op_subi, 16, 0, 5, 0, 0);
        send(16'hB63F, 10'h00B, op_in, 3, 0, 12'h03F, 0, 2);
        send(16'hBA72, 10'h00C, op_out, 0, 7, 12'h012, 0, 0);
        send(16'h9A2B, 10'h00D, op_sbi, 0, 0, 5, 3, 0);
        send(16'h98FF, 10'h00E, op_cbi, 0, 0, 12'h01F, 7, 0);
        send(16'h9493, 10'h00F, op_inc, 9, 0, 0, 0, 0);
        send(16'h951A, 10'h010, op_dec, 17, 0, 0, 0, 0);
        send(16'h9401, 10'h011, op_neg, 0, 0, 0, 0, 0);
        send(16'h93EF, 10'h012, op_push, 0, 30, 0, 0, 0);
        send(16'h902F, 10'h013, op_pop, 2, 0, 0, 0, 0);
        send(16'h8048, 10'h014, op_ld_y, 4, 0, 0, 0, 0);
        send(16'hA525, 10'h015, op_lds, 18, 0, 12'h065, 0, 0);
        send(16'hA89F, 10'h016, op_sts, 0, 25, 12'h08F, 0, 0);
        send(16'h0000, 10'h017, op_nop, 0, 0, 0, 0, 0);
        send(16'hFFFF, 10'h018, op_unknown, 0, 0, 0, 0, 0);
        send(16'h0001, 10'h019, op_unknown, 0, 0, 0, 0, 0);
        finish_test("decode");

        send(16'hC005, 10'h100, op_rjmp, 0, 0, 12'h005, 0, 0);
        send(16'hCFFE, 10'h010, op_rjmp, 0, 0, 12'hFFE, 0, 0);
        send(16'hC7FF, 10'h3F0, op_rjmp, 0, 0, 12'h7FF, 0, 0);   // wraps
        branch(1'b0, 7'h7F, 1, 10'h000);
        branch(1'b1, 63, 2, 10'h3FF);
        branch(1'b1, 7'h40, 6, 10'h020);
        finish_test("targets");

        send(16'h9508, 10'h050, op_ret, 0, 0, 0, 0, 0);   // empty pop
        for (int i = 0; i < DEPTH + 1; i++)
            send(16'hD010, PCW'(10'h080 + 16 * i), op_rcall, 0, 0, 12'h010, 0, i % 2);
        for (int i = 0; i < DEPTH + 1; i++)
            send(16'h9508, PCW'(10'h200 + i), op_ret, 0, 0, 0, 0, 0);
        finish_test("return_stack");

        for (int i = 0; i < 24; i++) begin
            w = instr_t'($random(seed));
            if (i % 2 == 0) begin
                w[15:12] = 4'hC;
                send(w, PCW'($random(seed)), op_rjmp, 0, 0, w[11:0], 0, $random(seed) & 7);
            end else begin
                w[15:10] = 6'b111100;
                send(w, PCW'($random(seed)), op_brbs, 0, 0,
                     sext(int'(w[9:3]), 7) & 12'hfff, w[2:0], $random(seed) & 7);
            end
        end
        finish_test("random_backpressure");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
decode_pkg.sv
decode_unit.sv
flow_predictor.sv
issue_unit.sv
decode_stage_top.sv
decode_checker.sv
tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_decode_stage -o sim_decode \
    && ./obj_dir/sim_decode | tee sim.log

grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
